// File: Bender.yml
package:
  name: pcap_replay

sources:
  - replay_pkg.sv
  - replay_cfg_pkg.sv
  - packet_buffer.sv
  - capture_writer.sv
  - replay_config.sv
  - replay_reader.sv
  - pcap_replay_top.sv
  - target: test
    files:
      - pcap_replay_assertions.sv
      - tb_pcap_replay.sv

// File: capture_writer.sv
/*
 * Capture side of the replay engine.
 * Picks a queue from the one-hot destination field of the first word of
 * each packet and writes the packet into that queue's buffer region.
 * Packets without a destination are dropped, and a full region truncates
 * the packet with tlast forced on its last stored word.
 */
`timescale 1ns/1ps

module capture_writer (
  input  logic                    axi_aclk,
  input  logic                    reset,
  input  replay_pkg::axis_word_t  s_axis,
  input  logic                    s_axis_tvalid,
  output logic                    s_axis_tready,
  input  logic                    busy,
  input  logic                    clear,
  output replay_pkg::buf_wr_t     buf_wr,
  output replay_pkg::queue_fill_t queue_fill
);
  import replay_pkg::*;

  logic ready_armed;
  logic in_pkt;
  logic dropping;
  logic hit;
  logic word_drop;
  logic last_free;
  logic accept;
  qid_t cur_q;
  qid_t sel_q;
  qid_t word_q;

  // Input closed while replaying
  assign s_axis_tready = ready_armed & ~busy;
  assign accept        = s_axis_tvalid & s_axis_tready;

  // Lowest set destination bit wins
  always_comb begin
    hit   = 1'b0;
    sel_q = '0;
    for (int q = num_queues - 1; q >= 0; q--) begin
      if (s_axis.tuser[dst_port_pos + 2*q]) begin
        hit   = 1'b1;
        sel_q = qid_t'(q);
      end
    end
  end

  assign word_q    = in_pkt ? cur_q : sel_q;
  assign last_free = queue_fill[word_q] == fill_t'(queue_depth - 1);
  assign word_drop = (in_pkt ? dropping : ~hit) ||
                     (queue_fill[word_q] == fill_t'(queue_depth));

  // Region base is the queue index in the upper address bits
  always_comb begin
    buf_wr.en         = accept & ~word_drop;
    buf_wr.addr       = {word_q, queue_fill[word_q][buf_addr_width-$bits(qid_t)-1:0]};
    buf_wr.word       = s_axis;
    buf_wr.word.tlast = s_axis.tlast | last_free;
  end

  always_ff @(posedge axi_aclk) begin
    if (reset) begin
      ready_armed <= 1'b0;
      in_pkt      <= 1'b0;
      dropping    <= 1'b0;
      cur_q       <= '0;
      queue_fill  <= '0;
    end else begin
      ready_armed <= 1'b1;
      if (clear) begin
        queue_fill <= '0;
      end else if (buf_wr.en) begin
        queue_fill[word_q] <= queue_fill[word_q] + fill_t'(1);
      end
      if (accept) begin
        in_pkt   <= ~s_axis.tlast;
        cur_q    <= word_q;
        // Rest of the packet is lost once the region fills up
        dropping <= word_drop | last_free;
      end
    end
  end

endmodule

// File: compile.f
replay_pkg.sv
replay_cfg_pkg.sv
packet_buffer.sv
capture_writer.sv
replay_config.sv
replay_reader.sv
pcap_replay_top.sv
pcap_replay_assertions.sv
tb_pcap_replay.sv

// File: packet_buffer.sv
/*
 * On-chip packet store shared by all queues.
 * One write port from the capture side, one registered read port for the
 * replay side. Each queue owns a contiguous region of queue_depth words.
 */
`timescale 1ns/1ps

module packet_buffer (
  input  logic                                axi_aclk,
  input  replay_pkg::buf_wr_t                 buf_wr,
  input  logic [replay_pkg::buf_addr_width-1:0] rd_addr,
  output replay_pkg::axis_word_t              rd_word
);
  import replay_pkg::*;

  axis_word_t mem [num_queues*queue_depth];

  always_ff @(posedge axi_aclk) begin
    if (buf_wr.en) begin
      mem[buf_wr.addr] <= buf_wr.word;
    end
  end

  // Read data one cycle after the address
  always_ff @(posedge axi_aclk) begin
    rd_word <= mem[rd_addr];
  end

endmodule

// File: pcap_replay_assertions.sv
/*
 * Protocol checks bound into the replay top level.
 * Output words hold while stalled, capture stays closed during a replay
 * and no port claims valid right after reset.
 */
`timescale 1ns/1ps

module pcap_replay_assertions (
  input logic                                                axi_aclk,
  input logic                                                reset,
  input logic                                                s_axis_tready,
  input replay_pkg::axis_word_t [replay_pkg::num_queues-1:0] m_axis,
  input logic [replay_pkg::num_queues-1:0]                   m_axis_tvalid,
  input logic [replay_pkg::num_queues-1:0]                   m_axis_tready,
  input logic                                                busy
);
  import replay_pkg::*;

  for (genvar p = 0; p < num_queues; p++) begin : g_port
    stall_stable: assert property (
      @(posedge axi_aclk) disable iff (reset)
      m_axis_tvalid[p] && !m_axis_tready[p] |=> m_axis_tvalid[p] && $stable(m_axis[p])
    ) else $error("port %0d changed its word while stalled", p);
  end

  closed_while_busy: assert property (
    @(posedge axi_aclk) disable iff (reset) busy |-> !s_axis_tready
  ) else $error("input stream ready during a replay");

  quiet_after_reset: assert property (
    @(posedge axi_aclk) $past(reset) |-> m_axis_tvalid == '0
  ) else $error("output valid in the cycle after reset");

endmodule

bind pcap_replay_top pcap_replay_assertions i_assertions (
  .axi_aclk      (axi_aclk),
  .reset         (reset),
  .s_axis_tready (s_axis_tready),
  .m_axis        (m_axis),
  .m_axis_tvalid (m_axis_tvalid),
  .m_axis_tready (m_axis_tready),
  .busy          (busy)
);

// File: pcap_replay_top.sv
/*
 * Packet capture and replay engine, single clock domain.
 * Packets arriving on s_axis are sorted by destination port into four
 * buffer regions. A start command replays each region on its own output
 * stream as many times as the matching count register says.
 */
`timescale 1ns/1ps

module pcap_replay_top (
  input  logic                                          axi_aclk,
  input  logic                                          reset,
  input  replay_pkg::axis_word_t                        s_axis,
  input  logic                                          s_axis_tvalid,
  output logic                                          s_axis_tready,
  output replay_pkg::axis_word_t [replay_pkg::num_queues-1:0] m_axis,
  output logic [replay_pkg::num_queues-1:0]             m_axis_tvalid,
  input  logic [replay_pkg::num_queues-1:0]             m_axis_tready,
  input  logic                                          cfg_wr,
  input  replay_cfg_pkg::cfg_addr_t                     cfg_addr,
  input  logic [replay_cfg_pkg::count_width-1:0]        cfg_data,
  output logic                                          busy
);
  import replay_pkg::*;
  import replay_cfg_pkg::*;

  buf_wr_t                                 buf_wr;
  queue_fill_t                             queue_fill;
  logic [buf_addr_width-1:0]               rd_addr;
  axis_word_t                              rd_word;
  logic [num_queues-1:0][count_width-1:0]  replay_counts;
  logic                                    start;
  logic                                    clear;

  capture_writer i_capture_writer (
    .axi_aclk      (axi_aclk),
    .reset         (reset),
    .s_axis        (s_axis),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .busy          (busy),
    .clear         (clear),
    .buf_wr        (buf_wr),
    .queue_fill    (queue_fill)
  );

  packet_buffer i_packet_buffer (
    .axi_aclk (axi_aclk),
    .buf_wr   (buf_wr),
    .rd_addr  (rd_addr),
    .rd_word  (rd_word)
  );

  replay_config i_replay_config (
    .axi_aclk      (axi_aclk),
    .reset         (reset),
    .cfg_wr        (cfg_wr),
    .cfg_addr      (cfg_addr),
    .cfg_data      (cfg_data),
    .busy          (busy),
    .replay_counts (replay_counts),
    .start         (start),
    .clear         (clear)
  );

  replay_reader i_replay_reader (
    .axi_aclk      (axi_aclk),
    .reset         (reset),
    .start         (start),
    .replay_counts (replay_counts),
    .queue_fill    (queue_fill),
    .rd_addr       (rd_addr),
    .rd_word       (rd_word),
    .m_axis        (m_axis),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .busy          (busy)
  );

endmodule

// File: replay_cfg_pkg.sv
/*
 * Configuration side definitions of the replay engine.
 * Register map, command codes, replay count width and reader FSM states.
 */
package replay_cfg_pkg;

  localparam int count_width = 16;

  typedef enum logic [2:0] {
    reg_count_q0 = 3'd0,
    reg_count_q1 = 3'd1,
    reg_count_q2 = 3'd2,
    reg_count_q3 = 3'd3,
    reg_command  = 3'd4
  } cfg_addr_t;

  typedef enum logic [1:0] {
    cmd_none  = 2'd0,
    cmd_start = 2'd1,
    cmd_clear = 2'd2
  } cfg_cmd_t;

  typedef enum logic [1:0] {
    st_idle,
    st_select,
    st_stream,
    st_next
  } replay_state_t;

endpackage

// File: replay_config.sv
/*
 * Configuration registers of the replay engine.
 * Holds one replay count per queue and turns writes to the command
 * register into single-cycle start and clear pulses.
 */
`timescale 1ns/1ps

module replay_config (
  input  logic                                      axi_aclk,
  input  logic                                      reset,
  input  logic                                      cfg_wr,
  input  replay_cfg_pkg::cfg_addr_t                 cfg_addr,
  input  logic [replay_cfg_pkg::count_width-1:0]    cfg_data,
  input  logic                                      busy,
  output logic [replay_pkg::num_queues-1:0][replay_cfg_pkg::count_width-1:0] replay_counts,
  output logic                                      start,
  output logic                                      clear
);
  import replay_cfg_pkg::*;

  cfg_cmd_t cmd;

  assign cmd = cfg_cmd_t'(cfg_data[$bits(cfg_cmd_t)-1:0]);

  always_ff @(posedge axi_aclk) begin
    if (reset) begin
      replay_counts <= '0;
      start         <= 1'b0;
      clear         <= 1'b0;
    end else begin
      start <= 1'b0;
      clear <= 1'b0;
      if (cfg_wr) begin
        case (cfg_addr)
          reg_count_q0, reg_count_q1, reg_count_q2, reg_count_q3: begin
            // Counts stay put during a replay
            if (!busy) begin
              replay_counts[cfg_addr[1:0]] <= cfg_data;
            end
          end
          reg_command: begin
            case (cmd)
              cmd_start: start <= ~busy;
              cmd_clear: clear <= 1'b1;
              cmd_none:  ;
              default:   ;
            endcase
          end
          default: ;
        endcase
      end
    end
  end

endmodule

// File: replay_pkg.sv
/*
 * Data path types for the packet capture and replay engine.
 * Stream words, buffer write requests and per-queue fill counts live here.
 * Modules import this package inside their body; ports use scoped names.
 */
package replay_pkg;

  localparam int num_queues     = 4;
  localparam int data_width     = 64;
  localparam int tuser_width    = 32;
  localparam int dst_port_pos   = 24;
  localparam int queue_depth    = 64;
  localparam int buf_addr_width = 8;

  typedef logic [1:0] qid_t;

  // Holds 0 to queue_depth inclusive
  typedef logic [6:0] fill_t;

  typedef struct packed {
    logic [data_width-1:0]  tdata;
    logic [tuser_width-1:0] tuser;
    logic                   tlast;
  } axis_word_t;

  typedef struct packed {
    logic                      en;
    logic [buf_addr_width-1:0] addr;
    axis_word_t                word;
  } buf_wr_t;

  typedef fill_t [num_queues-1:0] queue_fill_t;

endpackage

// File: replay_reader.sv
/*
 * Replay side of the engine.
 * Walks the queues round-robin, one packet per turn, and streams each
 * packet from its buffer region to the queue's output port. Every port
 * has an output register plus a spare so the read latency of the buffer
 * survives back-pressure. busy covers the whole replay.
 */
`timescale 1ns/1ps

module replay_reader (
  input  logic                                        axi_aclk,
  input  logic                                        reset,
  input  logic                                        start,
  input  logic [replay_pkg::num_queues-1:0][replay_cfg_pkg::count_width-1:0] replay_counts,
  input  replay_pkg::queue_fill_t                     queue_fill,
  output logic [replay_pkg::buf_addr_width-1:0]       rd_addr,
  input  replay_pkg::axis_word_t                      rd_word,
  output replay_pkg::axis_word_t [replay_pkg::num_queues-1:0] m_axis,
  output logic [replay_pkg::num_queues-1:0]           m_axis_tvalid,
  input  logic [replay_pkg::num_queues-1:0]           m_axis_tready,
  output logic                                        busy
);
  import replay_pkg::*;
  import replay_cfg_pkg::*;

  replay_state_t                  state;
  qid_t                           cur;
  qid_t                           last;
  qid_t                           next_q;
  logic                           found;
  logic                           pend;
  logic                           issue;
  logic                           pkt_done;
  logic                           all_empty;
  logic [1:0]                     occ;
  fill_t                          offset [num_queues];
  logic [count_width-1:0]         reps [num_queues];
  logic [num_queues-1:0]          out_v;
  logic [num_queues-1:0]          spare_v;
  logic [num_queues-1:0]          take;
  logic [num_queues-1:0]          incoming;
  axis_word_t [num_queues-1:0]    spare_word;

  assign m_axis_tvalid = out_v;
  assign take          = out_v & m_axis_tready;
  assign rd_addr       = {cur, offset[cur][buf_addr_width-$bits(qid_t)-1:0]};
  assign all_empty     = ~|(out_v | spare_v) & ~pend;

  // A pending read always belongs to the queue being streamed
  always_comb begin
    incoming      = '0;
    incoming[cur] = pend;
  end

  // Words held by the port next cycle, not counting a read issued now
  assign occ = 2'(out_v[cur]) + 2'(spare_v[cur]) + 2'(incoming[cur]) - 2'(take[cur]);

  assign pkt_done = (pend && rd_word.tlast) || (!pend && offset[cur] >= queue_fill[cur]);
  assign issue    = (state == st_stream) && !pkt_done &&
                    (offset[cur] < queue_fill[cur]) && (occ <= 2'd1);

  // Round-robin search starting after the last served queue
  always_comb begin
    found  = 1'b0;
    next_q = last;
    for (int i = 1; i <= num_queues; i++) begin
      if (!found && reps[qid_t'(last + i)] != '0) begin
        found  = 1'b1;
        next_q = qid_t'(last + i);
      end
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (reset) begin
      state <= st_idle;
      busy  <= 1'b0;
      cur   <= '0;
      last  <= qid_t'(num_queues - 1);
      pend  <= 1'b0;
      for (int q = 0; q < num_queues; q++) begin
        offset[q] <= '0;
        reps[q]   <= '0;
      end
    end else begin
      pend <= issue;
      if (issue) begin
        offset[cur] <= offset[cur] + fill_t'(1);
      end
      case (state)
        st_idle: begin
          if (start) begin
            busy  <= 1'b1;
            last  <= qid_t'(num_queues - 1);
            state <= st_select;
            for (int q = 0; q < num_queues; q++) begin
              offset[q] <= '0;
              reps[q]   <= (queue_fill[q] == '0) ? '0 : replay_counts[q];
            end
          end
        end
        st_select: begin
          if (found) begin
            cur   <= next_q;
            state <= st_stream;
          end else if (all_empty) begin
            busy  <= 1'b0;
            state <= st_idle;
          end
        end
        st_stream: begin
          if (pkt_done) begin
            state <= st_next;
          end
        end
        st_next: begin
          last  <= cur;
          state <= st_select;
          // End of region closes one repetition
          if (offset[cur] >= queue_fill[cur]) begin
            offset[cur] <= '0;
            reps[cur]   <= reps[cur] - 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (reset) begin
      out_v   <= '0;
      spare_v <= '0;
    end else begin
      for (int p = 0; p < num_queues; p++) begin
        if (!out_v[p] || take[p]) begin
          out_v[p]   <= spare_v[p] | incoming[p];
          spare_v[p] <= spare_v[p] & incoming[p];
        end else if (incoming[p]) begin
          spare_v[p] <= 1'b1;
        end
      end
    end
  end

  // Spare drains first to keep word order
  always_ff @(posedge axi_aclk) begin
    for (int p = 0; p < num_queues; p++) begin
      if (!out_v[p] || take[p]) begin
        if (spare_v[p]) begin
          m_axis[p] <= spare_word[p];
        end else if (incoming[p]) begin
          m_axis[p] <= rd_word;
        end
        if (spare_v[p] && incoming[p]) begin
          spare_word[p] <= rd_word;
        end
      end else if (incoming[p]) begin
        spare_word[p] <= rd_word;
      end
    end
  end

endmodule

// File: tb_pcap_replay.sv
/*
 * Testbench for the packet capture and replay engine.
 * Each table row clears the buffer, captures a set of packets, programs the
 * replay counts and starts a replay. The words seen on every port are
 * compared with a per-queue model of what the capture should have stored.
 */
`timescale 1ns/1ps

module tb_pcap_replay;
  import replay_pkg::*;
  import replay_cfg_pkg::*;

  localparam int num_rows = 5;

  typedef logic [127:0] val_t;

  // Packet entries are {destination mask, word count}
  typedef struct packed {
    logic [3:0]       npkts;
    logic [0:7][11:0] pkts;
    logic [0:3][15:0] counts;
    logic [0:3][7:0]  exp_words;
    logic             bp;
  } row_t;

  logic                        axi_aclk;
  logic                        reset;
  axis_word_t                  s_axis;
  logic                        s_axis_tvalid;
  logic                        s_axis_tready;
  axis_word_t [num_queues-1:0] m_axis;
  logic [num_queues-1:0]       m_axis_tvalid;
  logic [num_queues-1:0]       m_axis_tready;
  logic                        cfg_wr;
  cfg_addr_t                   cfg_addr;
  logic [count_width-1:0]      cfg_data;
  logic                        busy;

  row_t       rows [num_rows];
  axis_word_t store [num_queues][$];
  axis_word_t got [num_queues][$];
  int         row_errors;
  int         rows_ok;
  int         rows_bad;

  pcap_replay_top i_dut (
    .axi_aclk      (axi_aclk),
    .reset         (reset),
    .s_axis        (s_axis),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .m_axis        (m_axis),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .cfg_wr        (cfg_wr),
    .cfg_addr      (cfg_addr),
    .cfg_data      (cfg_data),
    .busy          (busy)
  );

  initial begin
    axi_aclk = 1'b0;
    forever #10 axi_aclk = ~axi_aclk;
  end

  task automatic load_table();
    // Sorting by destination, one packet with no destination bit
    rows[0] = '{4'd7, {12'h103, 12'h202, 12'h404, 12'h801, 12'h002, 12'h602, 12'h903, 12'h000},
                {16'd1, 16'd1, 16'd1, 16'd1}, {8'd6, 8'd4, 8'd4, 8'd1}, 1'b0};
    // Repeats, a zero count and an empty queue
    rows[1] = '{4'd3, {12'h102, 12'h203, 12'h401, {5{12'h000}}},
                {16'd3, 16'd0, 16'd2, 16'd1}, {8'd6, 8'd0, 8'd2, 8'd0}, 1'b0};
    rows[2] = '{4'd6, {12'h104, 12'h802, 12'h203, 12'h101, 12'h405, 12'h801, {2{12'h000}}},
                {16'd2, 16'd2, 16'd2, 16'd2}, {8'd10, 8'd6, 8'd10, 8'd6}, 1'b1};
    // Queue 2 overflows in its second packet
    rows[3] = '{4'd4, {12'h428, 12'h41e, 12'h405, 12'h202, {4{12'h000}}},
                {16'd1, 16'd1, 16'd2, 16'd0}, {8'd0, 8'd2, 8'd128, 8'd0}, 1'b1};
    rows[4] = '{4'd1, {12'h803, {7{12'h000}}},
                {16'd1, 16'd1, 16'd1, 16'd1}, {8'd0, 8'd0, 8'd0, 8'd3}, 1'b0};
  endtask

  task automatic check(input string name, input val_t actual, input val_t expected);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      row_errors++;
    end
  endtask

  task automatic report_row(input string name);
    if (row_errors == 0) begin
      rows_ok++;
      $display("%s: ok", name);
    end else begin
      rows_bad++;
      $display("%s: %0d errors", name, row_errors);
    end
  endtask

  task automatic watchdog();
    int limit;
    int words;
    int maxc;
    limit = 0;
    for (int r = 0; r < num_rows; r++) begin
      words = 0;
      maxc  = 0;
      for (int i = 0; i < int'(rows[r].npkts); i++) begin
        words += int'(rows[r].pkts[i][7:0]);
      end
      for (int q = 0; q < num_queues; q++) begin
        if (int'(rows[r].counts[q]) > maxc) begin
          maxc = int'(rows[r].counts[q]);
        end
      end
      limit += 4 * (words * maxc + 50);
    end
    repeat (limit) @(posedge axi_aclk);
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("test failed");
    $finish;
  endtask

  task automatic cfg_write(input cfg_addr_t addr, input logic [count_width-1:0] data);
    @(posedge axi_aclk);
    #2;
    cfg_wr   = 1'b1;
    cfg_addr = addr;
    cfg_data = data;
    @(posedge axi_aclk);
    #2;
    cfg_wr = 1'b0;
  endtask

  task automatic send_packet(input logic [3:0] dst, input logic [7:0] len);
    int         q;
    bit         accepted;
    axis_word_t w;
    q = -1;
    for (int b = num_queues - 1; b >= 0; b--) begin
      if (dst[b]) begin
        q = b;
      end
    end
    @(posedge axi_aclk);
    #2;
    for (int i = 0; i < int'(len); i++) begin
      w.tdata = {$urandom, $urandom};
      w.tuser = $urandom;
      for (int b = 0; b < num_queues; b++) begin
        w.tuser[dst_port_pos + 2*b] = dst[b];
      end
      w.tlast       = (i == int'(len) - 1);
      s_axis        = w;
      s_axis_tvalid = 1'b1;
      do begin
        @(negedge axi_aclk);
        accepted = s_axis_tready;
        @(posedge axi_aclk);
        #2;
      end while (!accepted);
      // Last free slot of a region closes the packet
      if (q >= 0 && store[q].size() < queue_depth) begin
        if (store[q].size() == queue_depth - 1) begin
          w.tlast = 1'b1;
        end
        store[q].push_back(w);
      end
    end
    s_axis_tvalid = 1'b0;
  endtask

  task automatic collect(input logic bp);
    int cycles;
    bit seen_busy;
    bit done;
    cycles    = 0;
    seen_busy = 1'b0;
    done      = 1'b0;
    while (!done) begin
      @(posedge axi_aclk);
      #2;
      m_axis_tready = bp ? num_queues'($urandom) : '1;
      @(negedge axi_aclk);
      cycles++;
      // These words transfer on the coming edge
      for (int p = 0; p < num_queues; p++) begin
        if (m_axis_tvalid[p] && m_axis_tready[p]) begin
          got[p].push_back(m_axis[p]);
        end
      end
      if (busy) begin
        seen_busy = 1'b1;
        check("s_axis_tready", val_t'(s_axis_tready), val_t'(0));
      end else if (seen_busy) begin
        done = 1'b1;
      end else if (cycles > 8) begin
        $display("ERROR: busy did not rise after the start command");
        row_errors++;
        done = 1'b1;
      end
    end
  endtask

  task automatic run_row(input int r);
    int n;
    int depth;
    row_errors = 0;
    for (int p = 0; p < num_queues; p++) begin
      store[p].delete();
      got[p].delete();
    end
    cfg_write(reg_command, count_width'(cmd_clear));
    repeat (2) @(posedge axi_aclk);
    for (int i = 0; i < int'(rows[r].npkts); i++) begin
      send_packet(rows[r].pkts[i][11:8], rows[r].pkts[i][7:0]);
    end
    for (int q = 0; q < num_queues; q++) begin
      cfg_write(cfg_addr_t'(q), rows[r].counts[q]);
    end
    cfg_write(reg_command, count_width'(cmd_start));
    collect(rows[r].bp);
    for (int p = 0; p < num_queues; p++) begin
      depth = store[p].size();
      n     = depth * int'(rows[r].counts[p]);
      check($sformatf("m_axis[%0d] word count", p),
            val_t'(got[p].size()), val_t'(rows[r].exp_words[p]));
      check($sformatf("m_axis[%0d] model word count", p), val_t'(got[p].size()), val_t'(n));
      for (int i = 0; i < got[p].size() && i < n; i++) begin
        check($sformatf("m_axis[%0d] word %0d", p, i),
              val_t'(got[p][i]), val_t'(store[p][i % depth]));
      end
    end
  endtask

  initial begin
    reset         = 1'b1;
    s_axis        = '0;
    s_axis_tvalid = 1'b0;
    m_axis_tready = '0;
    cfg_wr        = 1'b0;
    cfg_addr      = reg_count_q0;
    cfg_data      = '0;
    rows_ok       = 0;
    rows_bad      = 0;
    row_errors    = 0;
    void'($urandom(88544));
    load_table();
    fork
      watchdog();
    join_none
    repeat (9) @(posedge axi_aclk);
    // Everything quiet while reset is held
    @(negedge axi_aclk);
    check("busy", val_t'(busy), val_t'(0));
    check("s_axis_tready", val_t'(s_axis_tready), val_t'(0));
    check("m_axis_tvalid", val_t'(m_axis_tvalid), val_t'(0));
    report_row("reset");
    @(posedge axi_aclk);
    #2;
    reset = 1'b0;
    for (int r = 0; r < num_rows; r++) begin
      run_row(r);
      report_row($sformatf("row %0d", r));
    end
    $display("summary: %0d clean, %0d with errors", rows_ok, rows_bad);
    if (rows_bad == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
